// ==== flist.f ====
+incdir+include
rtl/memctrl_pkg.sv
rtl/mem_arbiter.sv
rtl/byte_sequencer.sv
rtl/word_assembler.sv
rtl/byte_ram.sv
rtl/mem_subsys_top.sv
tests/mem_subsys_asserts.sv
tests/mem_subsys_tb.sv

// ==== tests/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module mem_subsys_tb;
    import memctrl_pkg::*;

    localparam int    ClkPeriod      = 100;
    localparam int    DriveDly       = 1;
    localparam int    SampleDly      = 4;
    localparam int    ResetCycles    = 4;
    localparam int    RamBytes       = 2 ** `MC_RAM_AW;
    localparam addr_t RegionBase     = addr_t'(32'h100);
    localparam int    RegionBytes    = 64;
    localparam int    StoreOps       = 24;
    localparam int    LoadOps        = 30;
    localparam int    PauseOps       = 40;
    localparam int    JobBound       = 12;
    localparam int    PausedJobBound = 80;
    // each job is capped by its own bound, so their sum caps the run
    localparam int    CycleLimit     = ResetCycles + 20
        + (RegionBytes / 4 + StoreOps + LoadOps + 8 + 3) * (JobBound + 2)
        + PauseOps * (PausedJobBound + 2) + 100;

    logic  clk;
    logic  rst;
    logic  rdy;
    logic  ioFull;
    logic  infEn;
    addr_t infAddr;
    logic  dcEn;
    logic  dcStore;
    len_e  dcLen;
    word_t dcWdata;
    addr_t dcAddr;
    logic  infDone;
    word_t infInst;
    logic  dcDone;
    word_t dcRdata;
    logic  infWait;
    logic  dcWait;

    // expected RAM contents
    byte_t model [RamBytes];
    int    cycleCount = 0;

    mem_subsys_top i_mem_subsys_top (
        .clk       (clk),
        .rst       (rst),
        .i_rdy     (rdy),
        .i_ioFull  (ioFull),
        .i_infEn   (infEn),
        .i_infAddr (infAddr),
        .i_dcEn    (dcEn),
        .i_dcStore (dcStore),
        .i_dcLen   (dcLen),
        .i_dcData  (dcWdata),
        .i_dcAddr  (dcAddr),
        .o_infDone (infDone),
        .o_infInst (infInst),
        .o_dcDone  (dcDone),
        .o_dcData  (dcRdata),
        .o_infWait (infWait),
        .o_dcWait  (dcWait)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("run stopped after %0d cycles without finishing", cycleCount);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compareWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic compareCycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #DriveDly;
    endtask

    // rdy low, ioFull high, or both, in about one cycle of four
    task automatic drivePause(input bit usePauses, output bit paused);
        int pick;
        rdy    = 1'b1;
        ioFull = 1'b0;
        paused = 1'b0;
        if (usePauses && $urandom_range(3) == 0) begin
            pick   = $urandom_range(2);
            rdy    = (pick == 1);
            ioFull = (pick != 0);
            paused = 1'b1;
        end
    endtask

    // little-endian and zero-extended
    function automatic word_t modelWord(input addr_t addr, input int nBytes);
        word_t w;
        w = '0;
        for (int k = 0; k < nBytes; k++) begin
            w[`MC_BYTE_W*k +: `MC_BYTE_W] = model[(addr + k) % RamBytes];
        end
        return w;
    endfunction

    task automatic modelStore(input addr_t addr, input int nBytes, input word_t data);
        for (int k = 0; k < nBytes; k++) begin
            model[(addr + k) % RamBytes] = data[`MC_BYTE_W*k +: `MC_BYTE_W];
        end
    endtask

    function automatic len_e pickLen(input int idx);
        case (idx % 3)
            0:       return LEN_1;
            1:       return LEN_2;
            default: return LEN_4;
        endcase
    endfunction

    function automatic addr_t randomAddr();
        return RegionBase + addr_t'($urandom_range(RegionBytes - 4));
    endfunction

    // holds one request until its done pulse, a latency of -1 skips the timing check
    task automatic runAccess(input bit isFetch, input bit isStore, input len_e len,
                             input addr_t addr, input word_t wdata, input bit usePauses,
                             input int expLatency, output word_t result);
        bit paused;
        bit done;
        int cyc;
        int doneCyc;
        int bound;
        bound   = usePauses ? PausedJobBound : JobBound;
        done    = 1'b0;
        cyc     = -1;
        doneCyc = 0;
        result  = '0;
        nextCycle();
        drivePause(usePauses, paused);
        if (isFetch) begin
            infEn   = 1'b1;
            infAddr = addr;
        end else begin
            dcEn    = 1'b1;
            dcStore = isStore;
            dcLen   = len;
            dcAddr  = addr;
            dcWdata = wdata;
        end
        while (!done && cyc < bound) begin
            cyc++;
            nextCycle();
            drivePause(usePauses, paused);
            #SampleDly;
            if (paused) begin
                compareBit("o_infDone", infDone, 1'b0);
                compareBit("o_dcDone", dcDone, 1'b0);
            end
            compareBit(isFetch ? "o_dcDone" : "o_infDone", isFetch ? dcDone : infDone, 1'b0);
            if (isFetch ? infDone : dcDone) begin
                // requester drops its level in the done cycle
                done    = 1'b1;
                doneCyc = cyc;
                result  = isFetch ? infInst : dcRdata;
                infEn   = 1'b0;
                dcEn    = 1'b0;
            end
        end
        if (!done) begin
            abortRun($sformatf("no done pulse within %0d cycles of a request", bound));
        end else if (expLatency >= 0) begin
            compareCycles("done latency", doneCyc, expLatency);
        end
    endtask

    task automatic checkResetState();
        for (int i = 0; i < 8; i++) begin
            nextCycle();
            #SampleDly;
            compareBit("o_infDone", infDone, 1'b0);
            compareBit("o_dcDone", dcDone, 1'b0);
            compareBit("o_infWait", infWait, 1'b0);
            compareBit("o_dcWait", dcWait, 1'b0);
        end
    endtask

    task automatic testStoreLoad();
        word_t result;
        word_t data;
        addr_t addr;
        len_e  len;
        // whole words first so every later load sees written bytes
        for (int i = 0; i < RegionBytes / 4; i++) begin
            addr = RegionBase + addr_t'(4 * i);
            data = $urandom();
            runAccess(1'b0, 1'b1, LEN_4, addr, data, 1'b0, 4, result);
            modelStore(addr, 4, data);
            compareWord("o_dcData", result, '0);
        end
        for (int i = 0; i < StoreOps; i++) begin
            len  = pickLen(i);
            addr = randomAddr();
            data = $urandom();
            runAccess(1'b0, 1'b1, len, addr, data, 1'b0, int'(len), result);
            modelStore(addr, int'(len), data);
            compareWord("o_dcData", result, '0);
        end
        for (int i = 0; i < LoadOps; i++) begin
            len  = pickLen(i);
            addr = randomAddr();
            runAccess(1'b0, 1'b0, len, addr, '0, 1'b0, int'(len) + 1, result);
            compareWord("o_dcData", result, modelWord(addr, int'(len)));
        end
    endtask

    task automatic testFetch();
        word_t result;
        word_t data;
        addr_t addr;
        for (int i = 0; i < 4; i++) begin
            addr = RegionBase + addr_t'(4 * $urandom_range(RegionBytes / 4 - 1));
            data = $urandom();
            runAccess(1'b0, 1'b1, LEN_4, addr, data, 1'b0, 4, result);
            modelStore(addr, 4, data);
            runAccess(1'b1, 1'b0, LEN_4, addr, '0, 1'b0, 5, result);
            compareWord("o_infInst", result, modelWord(addr, 4));
        end
    endtask

    task automatic testPriority();
        addr_t loadAddr;
        addr_t fetchAddr;
        bit    dataSeen;
        bit    fetchSeen;
        int    cyc;
        loadAddr  = randomAddr();
        fetchAddr = randomAddr();
        dataSeen  = 1'b0;
        fetchSeen = 1'b0;
        cyc       = 0;
        nextCycle();
        rdy     = 1'b1;
        ioFull  = 1'b0;
        dcEn    = 1'b1;
        dcStore = 1'b0;
        dcLen   = LEN_4;
        dcAddr  = loadAddr;
        infEn   = 1'b1;
        infAddr = fetchAddr;
        while (!fetchSeen && cyc < 3 * JobBound) begin
            nextCycle();
            #SampleDly;
            if (!dataSeen) begin
                compareBit("o_infDone", infDone, 1'b0);
                if (dcDone) begin
                    compareWord("o_dcData", dcRdata, modelWord(loadAddr, 4));
                    dcEn     = 1'b0;
                    dataSeen = 1'b1;
                end else begin
                    compareBit("o_infWait", infWait, 1'b1);
                    compareBit("o_dcWait", dcWait, 1'b0);
                end
            end else if (infDone) begin
                compareWord("o_infInst", infInst, modelWord(fetchAddr, 4));
                infEn     = 1'b0;
                fetchSeen = 1'b1;
            end else begin
                compareBit("o_dcWait", dcWait, 1'b1);
            end
            cyc++;
        end
        if (!fetchSeen) begin
            abortRun("competing fetch and data requests did not both complete");
        end
    endtask

    task automatic testPauses();
        word_t result;
        word_t data;
        addr_t addr;
        len_e  len;
        for (int i = 0; i < PauseOps; i++) begin
            len  = pickLen(i);
            addr = randomAddr();
            if (i % 2 == 0) begin
                data = $urandom();
                runAccess(1'b0, 1'b1, len, addr, data, 1'b1, -1, result);
                modelStore(addr, int'(len), data);
                compareWord("o_dcData", result, '0);
            end else begin
                runAccess(1'b0, 1'b0, len, addr, '0, 1'b1, -1, result);
                compareWord("o_dcData", result, modelWord(addr, int'(len)));
            end
        end
        nextCycle();
        rdy    = 1'b1;
        ioFull = 1'b0;
    endtask

    initial begin
        void'($urandom(45540));
        rst     = 1'b1;
        rdy     = 1'b1;
        ioFull  = 1'b0;
        infEn   = 1'b0;
        infAddr = '0;
        dcEn    = 1'b0;
        dcStore = 1'b0;
        dcLen   = LEN_1;
        dcWdata = '0;
        dcAddr  = '0;
        repeat (ResetCycles) @(posedge clk);
        #DriveDly;
        rst = 1'b0;
        checkResetState();
        testStoreLoad();
        testFetch();
        testPriority();
        testPauses();
        nextCycle();
        if (i_mem_subsys_top.i_byte_sequencer.i_mem_subsys_asserts.failCount == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("assertions on the byte sequencer failed");
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== tests/mem_subsys_asserts.sv ====
`timescale 1ns/1ps

module mem_subsys_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 i_rdy,
    input logic                 i_ioFull,
    input memctrl_pkg::access_e i_job,
    input memctrl_pkg::stage_t  i_stage,
    input logic                 i_capture,
    input logic                 i_finish
);
    import memctrl_pkg::*;

    int   failCount = 0;
    logic paused;

    assign paused = !i_rdy || i_ioFull;

    // a paused cycle leaves the byte stage where it was
    stageHeldWhilePaused: assert property (@(posedge clk) disable iff (rst)
        paused |=> $stable(i_stage))
        else begin
            failCount = failCount + 1;
            $error("byte stage moved during a paused cycle");
        end

    finishIsPulse: assert property (@(posedge clk) disable iff (rst)
        i_finish |=> !i_finish)
        else begin
            failCount = failCount + 1;
            $error("finish held high for more than one cycle");
        end

    // captures belong to read jobs only
    captureOnReads: assert property (@(posedge clk) disable iff (rst)
        i_capture |-> (i_job == ACC_FETCH || i_job == ACC_LOAD))
        else begin
            failCount = failCount + 1;
            $error("capture strobe during a job that reads nothing");
        end

endmodule

bind byte_sequencer mem_subsys_asserts i_mem_subsys_asserts (
    .clk       (clk),
    .rst       (rst),
    .i_rdy     (i_rdy),
    .i_ioFull  (i_ioFull),
    .i_job     (i_job),
    .i_stage   (stage),
    .i_capture (o_capture),
    .i_finish  (o_finish)
);

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_rdy,
    input  logic               i_ioFull,
    input  logic               i_infEn,
    input  memctrl_pkg::addr_t i_infAddr,
    input  logic               i_dcEn,
    input  logic               i_dcStore,
    input  memctrl_pkg::len_e  i_dcLen,
    input  memctrl_pkg::word_t i_dcData,
    input  memctrl_pkg::addr_t i_dcAddr,
    output logic               o_infDone,
    output memctrl_pkg::word_t o_infInst,
    output logic               o_dcDone,
    output memctrl_pkg::word_t o_dcData,
    output logic               o_infWait,
    output logic               o_dcWait
);
    import memctrl_pkg::*;

    logic    start;
    access_e job;
    addr_t   base;
    len_e    len;
    word_t   storeData;
    logic    finish;
    addr_t   memAddr;
    logic    memWe;
    byte_t   memWdata;
    byte_t   memRdata;
    logic    capture;
    stage_t  captureIdx;

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_ioFull    (i_ioFull),
        .i_infEn     (i_infEn),
        .i_infAddr   (i_infAddr),
        .i_dcEn      (i_dcEn),
        .i_dcStore   (i_dcStore),
        .i_dcLen     (i_dcLen),
        .i_dcData    (i_dcData),
        .i_dcAddr    (i_dcAddr),
        .i_finish    (finish),
        .o_start     (start),
        .o_job       (job),
        .o_base      (base),
        .o_len       (len),
        .o_storeData (storeData),
        .o_infWait   (o_infWait),
        .o_dcWait    (o_dcWait)
    );

    byte_sequencer i_byte_sequencer (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_ioFull     (i_ioFull),
        .i_start      (start),
        .i_job        (job),
        .i_base       (base),
        .i_len        (len),
        .i_storeData  (storeData),
        .o_memAddr    (memAddr),
        .o_memWe      (memWe),
        .o_memWdata   (memWdata),
        .o_capture    (capture),
        .o_captureIdx (captureIdx),
        .o_finish     (finish)
    );

    byte_ram i_byte_ram (
        .clk     (clk),
        .i_we    (memWe),
        .i_addr  (memAddr),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

    word_assembler i_word_assembler (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_ioFull     (i_ioFull),
        .i_job        (job),
        .i_len        (len),
        .i_capture    (capture),
        .i_captureIdx (captureIdx),
        .i_memRdata   (memRdata),
        .i_finish     (finish),
        .o_infDone    (o_infDone),
        .o_infInst    (o_infInst),
        .o_dcDone     (o_dcDone),
        .o_dcData     (o_dcData)
    );

endmodule

// ==== rtl/byte_ram.sv ====
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module byte_ram (
    input  logic               clk,
    input  logic               i_we,
    input  memctrl_pkg::addr_t i_addr,
    input  memctrl_pkg::byte_t i_wdata,
    output memctrl_pkg::byte_t o_rdata
);
    import memctrl_pkg::*;

    localparam int Depth = 2 ** `MC_RAM_AW;

    byte_t mem [Depth];

    logic [`MC_RAM_AW-1:0] ramAddr;

    // upper address bits are not decoded
    assign ramAddr = i_addr[`MC_RAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[ramAddr] <= i_wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[ramAddr];
    end

endmodule

// ==== rtl/word_assembler.sv ====
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module word_assembler (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioFull,
    input  memctrl_pkg::access_e i_job,
    input  memctrl_pkg::len_e    i_len,
    input  logic                 i_capture,
    input  memctrl_pkg::stage_t  i_captureIdx,
    input  memctrl_pkg::byte_t   i_memRdata,
    input  logic                 i_finish,
    output logic                 o_infDone,
    output memctrl_pkg::word_t   o_infInst,
    output logic                 o_dcDone,
    output memctrl_pkg::word_t   o_dcData
);
    import memctrl_pkg::*;

    logic  paused;
    logic  infDoneQ;
    logic  dcDoneQ;
    word_t accum;
    word_t merged;
    word_t lenMask;

    assign paused = !i_rdy || i_ioFull;

    // current byte dropped into its lane
    always_comb begin
        merged = accum;
        if (i_capture) begin
            merged[`MC_BYTE_W*i_captureIdx +: `MC_BYTE_W] = i_memRdata;
        end
    end

    // zero-extension of short loads
    always_comb begin
        case (i_len)
            LEN_1:   lenMask = word_t'(32'h0000_00ff);
            LEN_2:   lenMask = word_t'(32'h0000_ffff);
            default: lenMask = '1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accum    <= '0;
            infDoneQ <= 1'b0;
            dcDoneQ  <= 1'b0;
        end else if (!paused) begin
            infDoneQ <= i_finish && (i_job == ACC_FETCH);
            dcDoneQ  <= i_finish && ((i_job == ACC_LOAD) || (i_job == ACC_STORE));
            // word starts from zero for the next job
            if (i_finish) begin
                accum <= '0;
            end else if (i_capture) begin
                accum <= merged;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!paused && i_finish) begin
            case (i_job)
                ACC_FETCH: o_infInst <= merged & lenMask;
                ACC_LOAD:  o_dcData  <= merged & lenMask;
                ACC_STORE: o_dcData  <= '0;
                default:   ;
            endcase
        end
    end

    // a done held over a pause shows once progress resumes
    assign o_infDone = infDoneQ && !paused;
    assign o_dcDone  = dcDoneQ && !paused;

endmodule

// ==== rtl/byte_sequencer.sv ====
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module byte_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,
    input  logic                 i_ioFull,
    input  logic                 i_start,
    input  memctrl_pkg::access_e i_job,
    input  memctrl_pkg::addr_t   i_base,
    input  memctrl_pkg::len_e    i_len,
    input  memctrl_pkg::word_t   i_storeData,
    output memctrl_pkg::addr_t   o_memAddr,
    output logic                 o_memWe,
    output memctrl_pkg::byte_t   o_memWdata,
    output logic                 o_capture,
    output memctrl_pkg::stage_t  o_captureIdx,
    output logic                 o_finish
);
    import memctrl_pkg::*;

    logic   paused;
    logic   issuing;
    logic   addrPhase;
    logic   readJob;
    logic   storeJob;
    logic   captureQ;
    stage_t stage;
    stage_t captureIdxQ;
    stage_t lastStage;
    stage_t memIdx;
    logic   storeFinish;
    logic   readFinish;

    assign paused    = !i_rdy || i_ioFull;
    assign readJob   = (i_job == ACC_FETCH) || (i_job == ACC_LOAD);
    assign storeJob  = (i_job == ACC_STORE);
    assign lastStage = stage_t'(i_len) - 3'd1;

    // addresses go out from the start cycle onward
    assign addrPhase = i_start || issuing;

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing  <= 1'b0;
            stage    <= '0;
            captureQ <= 1'b0;
        end else if (!paused) begin
            if (addrPhase) begin
                if (stage == lastStage) begin
                    issuing <= 1'b0;
                    stage   <= '0;
                end else begin
                    issuing <= 1'b1;
                    stage   <= stage + 3'd1;
                end
            end
            // read data shows up one cycle after its address
            captureQ <= addrPhase && readJob;
        end
    end

    always_ff @(posedge clk) begin
        if (!paused) begin
            captureIdxQ <= stage;
        end
    end

    // a pause with a capture pending re-reads that byte,
    // so the RAM output is still right when progress resumes
    always_comb begin
        if (paused && captureQ) begin
            memIdx = captureIdxQ;
        end else begin
            memIdx = stage;
        end
    end

    assign o_memAddr  = i_base + addr_t'(memIdx);
    assign o_memWe    = addrPhase && storeJob && !paused;
    assign o_memWdata = i_storeData[`MC_BYTE_W*stage +: `MC_BYTE_W];

    assign o_capture    = captureQ && !paused;
    assign o_captureIdx = captureIdxQ;

    // last write, or last captured byte
    assign storeFinish = o_memWe && (stage == lastStage);
    assign readFinish  = o_capture && (captureIdxQ == lastStage);
    assign o_finish    = storeFinish || readFinish;

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rdy,
    input  logic                i_ioFull,
    input  logic                i_infEn,
    input  memctrl_pkg::addr_t  i_infAddr,
    input  logic                i_dcEn,
    input  logic                i_dcStore,
    input  memctrl_pkg::len_e   i_dcLen,
    input  memctrl_pkg::word_t  i_dcData,
    input  memctrl_pkg::addr_t  i_dcAddr,
    input  logic                i_finish,
    output logic                o_start,
    output memctrl_pkg::access_e o_job,
    output memctrl_pkg::addr_t  o_base,
    output memctrl_pkg::len_e   o_len,
    output memctrl_pkg::word_t  o_storeData,
    output logic                o_infWait,
    output logic                o_dcWait
);
    import memctrl_pkg::*;

    logic paused;
    logic idle;

    assign paused = !i_rdy || i_ioFull;
    assign idle   = (o_job == ACC_IDLE);

    // job state and start pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            o_job   <= ACC_IDLE;
            o_start <= 1'b0;
        end else if (!paused) begin
            if (idle) begin
                // data side wins when both ask
                if (i_dcEn) begin
                    o_job <= i_dcStore ? ACC_STORE : ACC_LOAD;
                end else if (i_infEn) begin
                    o_job <= ACC_FETCH;
                end
                o_start <= i_dcEn || i_infEn;
            end else begin
                o_start <= 1'b0;
                if (i_finish) begin
                    o_job <= ACC_IDLE;
                end
            end
        end
    end

    // latched request fields
    always_ff @(posedge clk) begin
        if (!paused && idle) begin
            if (i_dcEn) begin
                o_base      <= i_dcAddr;
                o_len       <= i_dcLen;
                o_storeData <= i_dcData;
            end else if (i_infEn) begin
                o_base      <= i_infAddr;
                o_len       <= LEN_4;
                o_storeData <= '0;
            end
        end
    end

    assign o_infWait = (o_job == ACC_LOAD) || (o_job == ACC_STORE);
    assign o_dcWait  = (o_job == ACC_FETCH);

endmodule

// ==== rtl/memctrl_pkg.sv ====
`include "memctrl_macros.svh"

package memctrl_pkg;

    typedef logic [`MC_ADDR_W-1:0] addr_t;

    typedef logic [`MC_WORD_W-1:0] word_t;

    typedef logic [`MC_BYTE_W-1:0] byte_t;

    // value equals the number of bytes
    typedef enum logic [2:0] {
        LEN_1 = 3'd1,
        LEN_2 = 3'd2,
        LEN_4 = 3'd4
    } len_e;

    typedef enum logic [1:0] {
        ACC_IDLE  = 2'd0,
        ACC_FETCH = 2'd1,
        ACC_LOAD  = 2'd2,
        ACC_STORE = 2'd3
    } access_e;

    // byte stage within a job
    typedef logic [2:0] stage_t;

endpackage

// ==== include/memctrl_macros.svh ====
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// byte address width
`define MC_ADDR_W 32

// instruction and data words
`define MC_WORD_W 32

// one RAM byte
`define MC_BYTE_W 8

// decoded RAM address bits, 1 KiB
`define MC_RAM_AW 10

`endif
